// ==== Bender.yml ====
package:
  name: pipe_cpu

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/core_pkg.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/alu_stage.sv
      - logic/mem_stage.sv
      - logic/rbank.sv
      - logic/cpu.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/tb_cpu.sv

// ==== filelist.f ====
logic/isa_pkg.sv
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/alu_stage.sv
logic/mem_stage.sv
logic/rbank.sv
logic/cpu.sv
verif/clk_gen.sv
verif/tb_cpu.sv

// ==== logic/alu_stage.sv ====
`timescale 1ns/1ps

module alu_stage #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] pc_i,
  input  logic [DATA_WIDTH-1:0] data_a_i,
  input  logic [DATA_WIDTH-1:0] data_b_i,
  input  logic [DATA_WIDTH-1:0] imm_i,
  input  core_pkg::alu_op_e     alu_op_i,
  input  core_pkg::opnd_sel_e   opnd_sel_i,
  input  logic                  is_branch_i,
  input  logic                  is_jump_i,
  output logic                  valid_o,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic                  redirect_o,
  output logic [DATA_WIDTH-1:0] redirect_pc_o
);

  logic [DATA_WIDTH-1:0] opnd_b;
  logic                  equal;

  assign opnd_b = (opnd_sel_i == core_pkg::OPND_IMM) ? imm_i : data_b_i;

  always_comb begin
    case (alu_op_i)
      core_pkg::ALU_ADD: result_o = data_a_i + opnd_b;
      core_pkg::ALU_SUB: result_o = data_a_i - opnd_b;
      core_pkg::ALU_AND: result_o = data_a_i & opnd_b;
      core_pkg::ALU_OR:  result_o = data_a_i | opnd_b;
      core_pkg::ALU_XOR: result_o = data_a_i ^ opnd_b;
      default:           result_o = '0;
    endcase
  end

  // BEQ always compares the two registers, whatever the operand select
  assign equal = (data_a_i == data_b_i);

  assign redirect_o    = valid_i && (is_jump_i || (is_branch_i && equal));
  assign redirect_pc_o = is_jump_i ? imm_i : pc_i + 1'b1 + imm_i;
  assign valid_o       = valid_i;

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  typedef enum logic {
    OPND_REG = 1'b0,
    OPND_IMM = 1'b1  // Second operand from the sign-extended immediate
  } opnd_sel_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_e;

endpackage

// ==== logic/cpu.sv ====
`timescale 1ns/1ps

module cpu #(
  parameter int DATA_WIDTH = 32,
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               imem_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0]      imem_addr_i,
  input  logic [isa_pkg::INSTR_WIDTH-1:0]    imem_data_i,
  output logic                               retire_valid_o,
  output logic [DATA_WIDTH-1:0]              retire_pc_o,
  output logic                               retire_wr_en_o,
  output logic [isa_pkg::REG_ADDR_WIDTH-1:0] retire_reg_o,
  output logic [DATA_WIDTH-1:0]              retire_data_o,
  output logic                               retire_store_o,
  output logic [DATA_WIDTH-1:0]              retire_addr_o
);

  localparam int RW = isa_pkg::REG_ADDR_WIDTH;

  logic                            f_valid, fd_valid;
  logic [DATA_WIDTH-1:0]           f_pc, fd_pc;
  logic [isa_pkg::INSTR_WIDTH-1:0] f_instr, fd_instr;

  logic                  d_valid, d_wr_en, d_is_load, d_is_store, d_is_branch, d_is_jump;
  logic [RW-1:0]         d_ra, d_rb, d_rd;
  logic [DATA_WIDTH-1:0] d_imm, d_data_a, d_data_b;
  core_pkg::alu_op_e     d_alu_op;
  core_pkg::opnd_sel_e   d_opnd_sel;
  core_pkg::wb_sel_e     d_wb_sel;

  logic                  de_valid, de_wr_en, de_is_load, de_is_store, de_is_branch, de_is_jump;
  logic [RW-1:0]         de_rd;
  logic [DATA_WIDTH-1:0] de_pc, de_imm, de_data_a, de_data_b;
  core_pkg::alu_op_e     de_alu_op;
  core_pkg::opnd_sel_e   de_opnd_sel;
  core_pkg::wb_sel_e     de_wb_sel;

  logic                  e_valid, e_redirect;
  logic [DATA_WIDTH-1:0] e_result, e_redirect_pc;

  logic                  em_valid, em_wr_en, em_is_load, em_is_store;
  logic [RW-1:0]         em_rd;
  logic [DATA_WIDTH-1:0] em_pc, em_result, em_store_data, m_load_data;
  core_pkg::wb_sel_e     em_wb_sel;

  logic                  mw_valid, mw_wr_en, mw_is_store;
  logic [RW-1:0]         mw_rd;
  logic [DATA_WIDTH-1:0] mw_pc, mw_result, mw_store_data, mw_load_data, wb_data;
  core_pkg::wb_sel_e     mw_wb_sel;

  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
    .clk_i(clk_i), .rst_i(rst_i),
    .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
    .redirect_i(e_redirect), .redirect_pc_i(e_redirect_pc),
    .valid_o(f_valid), .pc_o(f_pc), .instr_o(f_instr)
  );

  decode_stage u_decode (
    .valid_i(fd_valid), .instr_i(fd_instr), .squash_i(e_redirect),
    .valid_o(d_valid), .ra_o(d_ra), .rb_o(d_rb), .rd_o(d_rd), .wr_en_o(d_wr_en),
    .imm_o(d_imm), .alu_op_o(d_alu_op), .opnd_sel_o(d_opnd_sel), .wb_sel_o(d_wb_sel),
    .is_load_o(d_is_load), .is_store_o(d_is_store),
    .is_branch_o(d_is_branch), .is_jump_o(d_is_jump)
  );

  rbank #(.DATA_WIDTH(DATA_WIDTH)) u_rbank (
    .clk_i(clk_i), .rst_i(rst_i), .rd_a_i(d_ra), .rd_b_i(d_rb),
    .wr_en_i(mw_valid && mw_wr_en), .wr_reg_i(mw_rd), .wr_data_i(wb_data),
    .data_a_o(d_data_a), .data_b_o(d_data_b)
  );

  alu_stage #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
    .valid_i(de_valid), .pc_i(de_pc), .data_a_i(de_data_a), .data_b_i(de_data_b),
    .imm_i(de_imm), .alu_op_i(de_alu_op), .opnd_sel_i(de_opnd_sel),
    .is_branch_i(de_is_branch), .is_jump_i(de_is_jump),
    .valid_o(e_valid), .result_o(e_result),
    .redirect_o(e_redirect), .redirect_pc_o(e_redirect_pc)
  );

  mem_stage #(.DATA_WIDTH(DATA_WIDTH), .DMEM_WORDS(DMEM_WORDS)) u_mem (
    .clk_i(clk_i), .rst_i(rst_i),
    .valid_i(em_valid && (em_is_load || em_is_store)), .is_store_i(em_is_store),
    .addr_i(em_result), .store_data_i(em_store_data), .load_data_o(m_load_data)
  );

  assign wb_data = (mw_wb_sel == core_pkg::WB_MEM) ? mw_load_data : mw_result;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      fd_valid       <= 1'b0;
      de_valid       <= 1'b0;
      em_valid       <= 1'b0;
      mw_valid       <= 1'b0;
      retire_valid_o <= 1'b0;
    end else begin
      fd_valid       <= f_valid && !e_redirect;  // Squash the slot behind a taken redirect
      de_valid       <= d_valid;
      em_valid       <= e_valid;
      mw_valid       <= em_valid;
      retire_valid_o <= mw_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    fd_pc         <= f_pc;
    fd_instr      <= f_instr;
    de_pc         <= fd_pc;
    de_rd         <= d_rd;
    de_wr_en      <= d_wr_en;
    de_imm        <= d_imm;
    de_data_a     <= d_data_a;
    de_data_b     <= d_data_b;
    de_alu_op     <= d_alu_op;
    de_opnd_sel   <= d_opnd_sel;
    de_wb_sel     <= d_wb_sel;
    de_is_load    <= d_is_load;
    de_is_store   <= d_is_store;
    de_is_branch  <= d_is_branch;
    de_is_jump    <= d_is_jump;
    em_pc         <= de_pc;
    em_rd         <= de_rd;
    em_wr_en      <= de_wr_en;
    em_wb_sel     <= de_wb_sel;
    em_is_load    <= de_is_load;
    em_is_store   <= de_is_store;
    em_result     <= e_result;
    em_store_data <= de_data_b;
    mw_pc         <= em_pc;
    mw_rd         <= em_rd;
    mw_wr_en      <= em_wr_en;
    mw_wb_sel     <= em_wb_sel;
    mw_is_store   <= em_is_store;
    mw_result     <= em_result;
    mw_store_data <= em_store_data;
    mw_load_data  <= m_load_data;
    retire_pc_o    <= mw_pc;
    retire_wr_en_o <= mw_wr_en;
    retire_reg_o   <= mw_rd;
    retire_data_o  <= mw_is_store ? mw_store_data : wb_data;  // Stores report the stored word
    retire_store_o <= mw_is_store;
    retire_addr_o  <= mw_is_store ? mw_result : '0;
  end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                                valid_i,
  input  logic [isa_pkg::INSTR_WIDTH-1:0]     instr_i,
  input  logic                                squash_i,
  output logic                                valid_o,
  output logic [isa_pkg::REG_ADDR_WIDTH-1:0]  ra_o,
  output logic [isa_pkg::REG_ADDR_WIDTH-1:0]  rb_o,
  output logic [isa_pkg::REG_ADDR_WIDTH-1:0]  rd_o,
  output logic                                wr_en_o,
  output logic [isa_pkg::INSTR_WIDTH-1:0]     imm_o,
  output core_pkg::alu_op_e                   alu_op_o,
  output core_pkg::opnd_sel_e                 opnd_sel_o,
  output core_pkg::wb_sel_e                   wb_sel_o,
  output logic                                is_load_o,
  output logic                                is_store_o,
  output logic                                is_branch_o,
  output logic                                is_jump_o
);

  isa_pkg::opcode_e opcode;
  logic             writes_rd;

  assign opcode = isa_pkg::opcode_e'(instr_i[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_WIDTH]);
  assign ra_o   = instr_i[isa_pkg::RA_LSB +: isa_pkg::REG_ADDR_WIDTH];
  assign rb_o   = instr_i[isa_pkg::RB_LSB +: isa_pkg::REG_ADDR_WIDTH];
  assign rd_o   = instr_i[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_WIDTH];
  assign imm_o  = {{(isa_pkg::INSTR_WIDTH - isa_pkg::IMM_WIDTH){instr_i[isa_pkg::IMM_WIDTH-1]}},
                   instr_i[isa_pkg::IMM_WIDTH-1:0]};

  always_comb begin
    alu_op_o    = core_pkg::ALU_ADD;
    opnd_sel_o  = core_pkg::OPND_REG;
    wb_sel_o    = core_pkg::WB_ALU;
    writes_rd   = 1'b0;
    is_load_o   = 1'b0;
    is_store_o  = 1'b0;
    is_branch_o = 1'b0;
    is_jump_o   = 1'b0;
    case (opcode)
      isa_pkg::OP_ADD: writes_rd = 1'b1;
      isa_pkg::OP_SUB: begin
        alu_op_o  = core_pkg::ALU_SUB;
        writes_rd = 1'b1;
      end
      isa_pkg::OP_AND: begin
        alu_op_o  = core_pkg::ALU_AND;
        writes_rd = 1'b1;
      end
      isa_pkg::OP_OR: begin
        alu_op_o  = core_pkg::ALU_OR;
        writes_rd = 1'b1;
      end
      isa_pkg::OP_XOR: begin
        alu_op_o  = core_pkg::ALU_XOR;
        writes_rd = 1'b1;
      end
      isa_pkg::OP_ADDI: begin
        opnd_sel_o = core_pkg::OPND_IMM;
        writes_rd  = 1'b1;
      end
      isa_pkg::OP_LW: begin
        opnd_sel_o = core_pkg::OPND_IMM;  // Address is ra + imm
        wb_sel_o   = core_pkg::WB_MEM;
        writes_rd  = 1'b1;
        is_load_o  = 1'b1;
      end
      isa_pkg::OP_SW: begin
        opnd_sel_o = core_pkg::OPND_IMM;
        is_store_o = 1'b1;  // Store data comes from rb
      end
      isa_pkg::OP_BEQ: is_branch_o = 1'b1;
      isa_pkg::OP_JMP: is_jump_o = 1'b1;
      default: ;  // Unused opcodes retire with no effect
    endcase
  end

  assign wr_en_o = writes_rd && (rd_o != '0);
  assign valid_o = valid_i && !squash_i;

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               imem_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0]      imem_addr_i,
  input  logic [isa_pkg::INSTR_WIDTH-1:0]    imem_data_i,
  input  logic                               redirect_i,
  input  logic [isa_pkg::INSTR_WIDTH-1:0]    redirect_pc_i,
  output logic                               valid_o,
  output logic [isa_pkg::INSTR_WIDTH-1:0]    pc_o,
  output logic [isa_pkg::INSTR_WIDTH-1:0]    instr_o
);

  localparam int IADDR_W = $clog2(IMEM_WORDS);

  logic [isa_pkg::INSTR_WIDTH-1:0] imem [IMEM_WORDS];
  logic [isa_pkg::INSTR_WIDTH-1:0] pc_q;
  logic                            run_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i && imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;  // Program load only while reset is held
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q  <= '0;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (run_q) begin
        pc_q <= redirect_i ? redirect_pc_i : pc_q + 1'b1;
      end
    end
  end

  assign valid_o = run_q;
  assign pc_o    = pc_q;
  assign instr_o = imem[pc_q[IADDR_W-1:0]];

  a_pc_in_range: assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_o |-> pc_q < IMEM_WORDS);

  a_load_in_reset: assert property (@(posedge clk_i) imem_we_i |-> !rst_i);

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  parameter int INSTR_WIDTH = 32;

  parameter int OPCODE_WIDTH = 4;
  parameter int REG_ADDR_WIDTH = 5;
  parameter int IMM_WIDTH = 13;
  parameter int REG_COUNT = 32;

  // Lowest bit of each instruction field
  parameter int OPCODE_LSB = 28;
  parameter int RD_LSB = 23;
  parameter int RA_LSB = 18;
  parameter int RB_LSB = 13;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_LW   = 4'd6,
    OP_SW   = 4'd7,
    OP_BEQ  = 4'd8,  // Target is pc + 1 + imm
    OP_JMP  = 4'd9   // Target is imm
  } opcode_e;

endpackage

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
  parameter int DATA_WIDTH = 32,
  parameter int DMEM_WORDS = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  is_store_i,
  input  logic [DATA_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] store_data_i,
  output logic [DATA_WIDTH-1:0] load_data_o
);

  localparam int DADDR_W = $clog2(DMEM_WORDS);

  logic [DATA_WIDTH-1:0] dmem [DMEM_WORDS];
  logic [DADDR_W-1:0]    clr_q = '0;  // Walks the array while reset is held

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      clr_q       <= clr_q + 1'b1;
      dmem[clr_q] <= '0;
    end else begin
      clr_q <= '0;
      if (valid_i && is_store_i) begin
        dmem[addr_i[DADDR_W-1:0]] <= store_data_i;
      end
    end
  end

  assign load_data_o = dmem[addr_i[DADDR_W-1:0]];

  a_addr_in_range: assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_i |-> addr_i < DMEM_WORDS);

endmodule

// ==== logic/rbank.sv ====
`timescale 1ns/1ps

module rbank #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_a_i,
  input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_b_i,
  input  logic                               wr_en_i,
  input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] wr_reg_i,
  input  logic [DATA_WIDTH-1:0]              wr_data_i,
  output logic [DATA_WIDTH-1:0]              data_a_o,
  output logic [DATA_WIDTH-1:0]              data_b_o
);

  logic [DATA_WIDTH-1:0] regs [isa_pkg::REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < isa_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_reg_i != '0) begin
      regs[wr_reg_i] <= wr_data_i;
    end
  end

  // Same-cycle write bypasses the array
  assign data_a_o = (rd_a_i == '0) ? '0 :
                    (wr_en_i && wr_reg_i == rd_a_i) ? wr_data_i : regs[rd_a_i];
  assign data_b_o = (rd_b_i == '0) ? '0 :
                    (wr_en_i && wr_reg_i == rd_b_i) ? wr_data_i : regs[rd_b_i];

  a_no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_i)
    wr_en_i |-> wr_reg_i != '0);

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b0;  // Active low, held from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b1;
  end

endmodule

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

  localparam int DATA_WIDTH = 32;
  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 64;
  localparam int RST_CYCLES = 80;
  localparam int PROG_LEN   = 48;
  localparam int RUN_LIMIT  = 4 * PROG_LEN + 100;  // No more than PROG_LEN entries can retire
  localparam logic [31:0] SEED = 32'h29f8;

  logic                          clk;
  logic                          rst;
  logic                          imem_we;
  logic [$clog2(IMEM_WORDS)-1:0] imem_addr;
  logic [31:0]                   imem_data;
  logic                          ret_valid;
  logic [DATA_WIDTH-1:0]         ret_pc;
  logic                          ret_wr_en;
  logic [4:0]                    ret_reg;
  logic [DATA_WIDTH-1:0]         ret_data;
  logic                          ret_store;
  logic [DATA_WIDTH-1:0]         ret_addr;

  integer      seed;
  logic [31:0] prog [IMEM_WORDS];
  int          dst [PROG_LEN];  // Register written by each static instruction, 0 for none
  logic [31:0] exp_pc [PROG_LEN];
  logic        exp_wr_en [PROG_LEN];
  logic [4:0]  exp_reg [PROG_LEN];
  logic [31:0] exp_data [PROG_LEN];
  logic        exp_store [PROG_LEN];
  logic [31:0] exp_addr [PROG_LEN];
  int          exp_count;
  int          ret_idx;

  clk_gen #(.PERIOD_NS(100), .RST_CYCLES(RST_CYCLES)) u_clk (.clk_o(clk), .rst_o(rst));

  cpu #(
    .DATA_WIDTH(DATA_WIDTH),
    .IMEM_WORDS(IMEM_WORDS),
    .DMEM_WORDS(DMEM_WORDS)
  ) dut0 (
    .clk_i(clk), .rst_i(rst),
    .imem_we_i(imem_we), .imem_addr_i(imem_addr), .imem_data_i(imem_data),
    .retire_valid_o(ret_valid), .retire_pc_o(ret_pc), .retire_wr_en_o(ret_wr_en),
    .retire_reg_o(ret_reg), .retire_data_o(ret_data),
    .retire_store_o(ret_store), .retire_addr_o(ret_addr)
  );

  function automatic int unsigned rand_below(int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] encode(isa_pkg::opcode_e op, int rd, int ra, int rb, int imm);
    logic [31:0] w;
    w        = '0;
    w[31:28] = op;
    w[27:23] = rd[4:0];
    w[22:18] = ra[4:0];
    w[17:13] = rb[4:0];
    w[12:0]  = imm[12:0];
    return w;
  endfunction

  // Register 0 is always safe to read, since nothing is ever written to it
  function automatic int pick_src(int idx);
    int r;
    int w1;
    int w2;
    w1 = (idx >= 1) ? dst[idx-1] : 0;
    w2 = (idx >= 2) ? dst[idx-2] : 0;
    r  = rand_below(8);
    while (r != 0 && (r == w1 || r == w2)) begin
      r = (r + 1) % 8;
    end
    return r;
  endfunction

  task automatic emit_data_op(int idx, bit to_r0);
    int kind;
    int rd;
    int ra;
    int rb;
    kind = to_r0 ? rand_below(6) : rand_below(8);
    rd   = to_r0 ? 0 : rand_below(8);
    ra   = pick_src(idx);
    rb   = pick_src(idx);
    case (kind)
      5: prog[idx] = encode(isa_pkg::OP_ADDI, rd, ra, 0, rand_below(8192));
      6: prog[idx] = encode(isa_pkg::OP_LW, rd, 0, 0, rand_below(DMEM_WORDS));
      7: begin
        prog[idx] = encode(isa_pkg::OP_SW, 0, 0, rb, rand_below(DMEM_WORDS));
        rd        = 0;
      end
      default: prog[idx] = encode(isa_pkg::opcode_e'(kind), rd, ra, rb, 0);
    endcase
    dst[idx] = rd;
  endtask

  task automatic emit_control(int idx);
    int span;
    int ra;
    int rb;
    span = PROG_LEN - 1 - idx;  // Forward targets up to the final self-jump
    ra   = pick_src(idx);
    rb   = (rand_below(2) == 0) ? ra : pick_src(idx);
    if (rand_below(2) == 0) begin
      prog[idx] = encode(isa_pkg::OP_BEQ, 0, ra, rb, rand_below(span));
    end else begin
      prog[idx] = encode(isa_pkg::OP_JMP, 0, 0, 0, idx + 1 + rand_below(span));
    end
    dst[idx] = 0;
  endtask

  task automatic gen_program();
    int i;
    i = 0;
    while (i < PROG_LEN - 1) begin
      if (i <= PROG_LEN - 4 && rand_below(4) == 0) begin
        emit_data_op(i, 1'b1);  // Branches and jumps follow a write to register 0
        emit_control(i + 1);
        i = i + 2;
      end else begin
        emit_data_op(i, i == PROG_LEN - 2);
        i = i + 1;
      end
    end
    prog[PROG_LEN-1] = encode(isa_pkg::OP_JMP, 0, 0, 0, PROG_LEN - 1);
    dst[PROG_LEN-1]  = 0;
    for (i = PROG_LEN; i < IMEM_WORDS; i++) begin
      prog[i] = encode(isa_pkg::OP_JMP, 0, 0, 0, i);
    end
  endtask

  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] ins;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        writes;
    int          pc;
    int          next_pc;
    int          rd;
    int          k;
    bit          done;
    for (k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    for (k = 0; k < DMEM_WORDS; k++) begin
      dmem[k] = '0;
    end
    pc        = 0;
    exp_count = 0;
    done      = 1'b0;
    while (!done && exp_count < PROG_LEN) begin
      ins     = prog[pc];
      rd      = ins[27:23];
      a       = regs[ins[22:18]];
      b       = regs[ins[17:13]];
      imm     = {{19{ins[12]}}, ins[12:0]};
      res     = '0;
      writes  = 1'b1;
      next_pc = pc + 1;
      exp_pc[exp_count]    = pc;
      exp_store[exp_count] = 1'b0;
      exp_addr[exp_count]  = '0;
      case (ins[31:28])
        isa_pkg::OP_ADD:  res = a + b;
        isa_pkg::OP_SUB:  res = a - b;
        isa_pkg::OP_AND:  res = a & b;
        isa_pkg::OP_OR:   res = a | b;
        isa_pkg::OP_XOR:  res = a ^ b;
        isa_pkg::OP_ADDI: res = a + imm;
        isa_pkg::OP_LW:   res = dmem[(a + imm) % DMEM_WORDS];
        isa_pkg::OP_SW: begin
          writes = 1'b0;
          dmem[(a + imm) % DMEM_WORDS] = b;
          exp_store[exp_count] = 1'b1;
          exp_addr[exp_count]  = a + imm;
          res = b;
        end
        isa_pkg::OP_BEQ: begin
          writes = 1'b0;
          if (a == b) begin
            next_pc = pc + 1 + int'(imm);
          end
        end
        default: begin
          writes  = 1'b0;  // JMP, the only other opcode in the program
          next_pc = int'(imm);
        end
      endcase
      exp_wr_en[exp_count] = writes && rd != 0;
      exp_reg[exp_count]   = rd[4:0];
      exp_data[exp_count]  = res;
      if (writes && rd != 0) begin
        regs[rd] = res;
      end
      exp_count = exp_count + 1;
      done      = (next_pc == pc);
      pc        = next_pc;
    end
  endtask

  task automatic load_program();
    int k;
    for (k = 0; k < IMEM_WORDS; k++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= k[$clog2(IMEM_WORDS)-1:0];
      imem_data <= prog[k];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "retire mismatch");
    end
  endtask

  initial begin
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    seed      = SEED;
    ret_idx   = 0;
    gen_program();
    run_model();
    load_program();
  end

  // Sampled on the falling edge, half a cycle after the retire registers settle
  initial begin
    @(posedge clk);
    while (ret_idx < exp_count) begin
      @(negedge clk);
      if (!rst) begin
        check("retire_valid_o during reset", ret_valid, 32'd0);
      end else if (ret_valid === 1'b1) begin
        check("retire pc", ret_pc, exp_pc[ret_idx]);
        check("retire write enable", ret_wr_en, exp_wr_en[ret_idx]);
        check("retire store flag", ret_store, exp_store[ret_idx]);
        if (exp_wr_en[ret_idx]) begin
          check("retire register", ret_reg, exp_reg[ret_idx]);
          check("retire write data", ret_data, exp_data[ret_idx]);
        end
        if (exp_store[ret_idx]) begin
          check("retire store address", ret_addr, exp_addr[ret_idx]);
          check("retire store data", ret_data, exp_data[ret_idx]);
        end
        ret_idx = ret_idx + 1;
      end else begin
        check("retire_valid_o after reset", ret_valid, 32'd0);
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    repeat (RST_CYCLES + RUN_LIMIT) @(posedge clk);
    $display("Watchdog: core stopped retiring instructions after %0d of %0d",
             ret_idx, exp_count);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog timeout");
  end

endmodule
